// File: axis_axil_target.f
verilog/aa_pkg.sv
verilog/aa_req_if.sv
verilog/ss_request_decode.sv
verilog/lm_execute.sv
verilog/aa_mailbox_regs.sv
verilog/sm_completion.sv
verilog/axis_axil_target.sv
tests/tb_axis_axil_target.sv

// File: Bender.yml
package:
  name: axis_axil_target

sources:
  - verilog/aa_pkg.sv
  - verilog/aa_req_if.sv
  - verilog/ss_request_decode.sv
  - verilog/lm_execute.sv
  - verilog/aa_mailbox_regs.sv
  - verilog/sm_completion.sv
  - verilog/axis_axil_target.sv
  - target: test
    files:
      - tests/tb_axis_axil_target.sv

// File: tests/testdata_axis_axil_target.txt
# op addr strb data expect, all hex; op W write, R read, J junk beat (tuser 00)
# expect is the mb_irq level after W and J, the completion data after R
W 00002100 1 00000001 0
W 00002000 f 11223344 1
R 00002104 0 00000000 00000001
W 00002104 1 00000001 0
R 00002104 0 00000000 00000000
W 00002000 3 aaaabbbb 1
R 00002000 0 00000000 1122bbbb
W 00002104 1 00000001 0
W 00002100 1 00000000 0
W 0000201c f 01020304 0
W 0000201c 4 00ee0000 0
R 0000201c 0 00000000 01ee0304
R 00002104 0 00000000 00000001
J 00000000 0 deadbeef 0
W 00000010 f cafef00d 0
R 00000010 0 00000000 cafef00d
W 0a000014 6 00abcd00 0
R 0a000014 0 00000000 5aabcd05
R 00000020 0 00000000 5a080808
J 00000000 0 40002000 0
R 00002100 0 00000000 00000000

// File: tests/tb_axis_axil_target.sv
/*
 * testbench for the stream-side configuration target
 * replays requests from the test data file against an AXI-Lite slave model
 * and a stalling completion sink
 */

`timescale 1ns/1ps

module tb_axis_axil_target;

  logic        axis_clk;
  logic        axis_rst_n;
  logic [31:0] as_aa_tdata;
  logic [1:0]  as_aa_tuser;
  logic        as_aa_tvalid;
  logic        aa_as_tready;
  logic [31:0] aa_as_tdata;
  logic [3:0]  aa_as_tstrb;
  logic [3:0]  aa_as_tkeep;
  logic        aa_as_tlast;
  logic        aa_as_tvalid;
  logic [1:0]  aa_as_tuser;
  logic        as_aa_tready;
  logic        m_awvalid;
  logic [31:0] m_awaddr;
  logic        m_awready;
  logic        m_wvalid;
  logic [31:0] m_wdata;
  logic [3:0]  m_wstrb;
  logic        m_wready;
  logic        m_arvalid;
  logic [31:0] m_araddr;
  logic        m_arready;
  logic        m_rready;
  logic        m_rvalid;
  logic [31:0] m_rdata;
  logic        mb_irq;

  // test data with one entry per data line
  byte         td_op [$];
  logic [31:0] td_addr [$];
  logic [3:0]  td_strb [$];
  logic [31:0] td_data [$];
  logic [31:0] td_exp [$];

  // slave model word store indexed by address bits 5..2
  logic [31:0] mem [16];
  logic [31:0] rng = 32'd4174;
  // request currently in flight as seen by the bus model
  logic [31:0] exp_addr = '0;
  logic [31:0] exp_data = '0;
  logic [3:0]  exp_strb = '0;

  int          error_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          wr_count = 0;
  int          rd_count = 0;
  int          cpl_count = 0;
  logic [31:0] cpl_data = '0;
  logic        hold_pend = 1'b0;
  logic [31:0] hold_data = '0;

  // slave channel state
  logic        wr_ack = 1'b0;
  logic [1:0]  wr_wait = '0;
  logic [3:0]  wr_idx;
  logic [31:0] wr_data_q;
  logic [3:0]  wr_strb_q;
  logic        ar_ack = 1'b0;
  logic [1:0]  ar_wait = '0;
  logic        rd_pend = 1'b0;
  logic [3:0]  rd_idx;
  logic        r_ack = 1'b0;
  logic [1:0]  r_wait = '0;

  axis_axil_target #(.p_addr_w(32), .p_data_w(32)) i_axis_axil_target (.*);

  always #20 axis_clk = ~axis_clk;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // mailbox and interrupt window in address bits 27..8
  function automatic logic in_local_window(input logic [31:0] a);
    return (a[27:8] == 20'h00020) || (a[27:8] == 20'h00021);
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                             input logic [3:0] strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  // ------------------------------------------------------------------
  // completion sink and AXI-Lite slave model on the falling edge
  // ------------------------------------------------------------------
  always @(negedge axis_clk) begin
    // a beat left waiting last cycle must not have moved
    if (hold_pend) begin
      check("aa_as_tvalid", aa_as_tvalid, 32'd1);
      check("aa_as_tdata", aa_as_tdata, hold_data);
    end
    rng = xorshift32(rng);
    as_aa_tready = (rng[1:0] != 2'b00);
    hold_pend = 1'b0;
    if (aa_as_tvalid) begin
      if (as_aa_tready) begin
        check("aa_as_tuser", aa_as_tuser, 32'h3);
        check("aa_as_tlast", aa_as_tlast, 32'h1);
        check("aa_as_tstrb", aa_as_tstrb, 32'hf);
        check("aa_as_tkeep", aa_as_tkeep, 32'h0);
        cpl_data = aa_as_tdata;
        cpl_count++;
      end else begin
        hold_pend = 1'b1;
        hold_data = aa_as_tdata;
      end
    end

    // write channel accepts aw and w together
    if (wr_ack) begin
      wr_ack = 1'b0;
      m_awready = 1'b0;
      m_wready = 1'b0;
      mem[wr_idx] = byte_merge(mem[wr_idx], wr_data_q, wr_strb_q);
      wr_count++;
    end else if (m_awvalid && m_wvalid) begin
      if (wr_wait == 0) begin
        check("m_awaddr", m_awaddr, {4'h3, exp_addr[27:0]});
        check("m_wdata", m_wdata, exp_data);
        check("m_wstrb", m_wstrb, exp_strb);
        wr_idx = m_awaddr[5:2];
        wr_data_q = m_wdata;
        wr_strb_q = m_wstrb;
        wr_ack = 1'b1;
        m_awready = 1'b1;
        m_wready = 1'b1;
        rng = xorshift32(rng);
        wr_wait = rng[3:2];
      end else begin
        wr_wait--;
      end
    end

    // read address channel
    if (ar_ack) begin
      ar_ack = 1'b0;
      m_arready = 1'b0;
      rd_pend = 1'b1;
    end else if (m_arvalid) begin
      if (ar_wait == 0) begin
        check("m_araddr", m_araddr, {4'h3, exp_addr[27:0]});
        rd_idx = m_araddr[5:2];
        ar_ack = 1'b1;
        m_arready = 1'b1;
        rng = xorshift32(rng);
        ar_wait = rng[5:4];
      end else begin
        ar_wait--;
      end
    end

    // read data channel holds rdata while rvalid is high
    if (r_ack) begin
      r_ack = 1'b0;
      m_rvalid = 1'b0;
      rd_count++;
    end else if (rd_pend && m_rready) begin
      if (r_wait == 0) begin
        m_rdata = mem[rd_idx];
        m_rvalid = 1'b1;
        r_ack = 1'b1;
        rd_pend = 1'b0;
        rng = xorshift32(rng);
        r_wait = rng[7:6];
      end else begin
        r_wait--;
      end
    end
  end

  // run limit scales with the number of data lines
  always @(posedge axis_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout reached after %0d cycles, the sequence did not finish", cycle_count);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  task automatic read_testdata();
    int          fd;
    int          n;
    string       line;
    byte         op_c;
    logic [31:0] a;
    logic [31:0] s;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("tests/testdata_axis_axil_target.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the test data file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h", op_c, a, s, d, e);
      if (n != 5) begin
        abort_run("malformed line in the test data file");
      end
      td_op.push_back(op_c);
      td_addr.push_back(a);
      td_strb.push_back(s[3:0]);
      td_data.push_back(d);
      td_exp.push_back(e);
    end
    $fclose(fd);
  endtask

  // called on a falling edge and returns on the falling edge after acceptance
  task automatic send_beat(input logic [31:0] d, input logic [1:0] u);
    as_aa_tdata = d;
    as_aa_tuser = u;
    as_aa_tvalid = 1'b1;
    while (!aa_as_tready) begin
      @(negedge axis_clk);
    end
    @(negedge axis_clk);
    as_aa_tvalid = 1'b0;
  endtask

  task automatic run_line(input int i);
    int          wr0;
    int          rd0;
    int          cpl0;
    logic        bus;
    logic [31:0] old_word;
    wr0 = wr_count;
    rd0 = rd_count;
    cpl0 = cpl_count;
    bus = !in_local_window(td_addr[i]);
    exp_addr = td_addr[i];
    exp_data = td_data[i];
    exp_strb = td_strb[i];
    old_word = mem[td_addr[i][5:2]];
    case (td_op[i])
      "W": begin
        send_beat({td_strb[i], td_addr[i][27:0]}, 2'b01);
        send_beat(td_data[i], 2'b01);
        while (!aa_as_tready) begin
          @(negedge axis_clk);
        end
        check("mb_irq", mb_irq, td_exp[i]);
        check("completion count", cpl_count, cpl0);
        check("bus read count", rd_count, rd0);
        check("bus write count", wr_count, bus ? wr0 + 1 : wr0);
        if (bus) begin
          check("slave word", mem[td_addr[i][5:2]],
                byte_merge(old_word, td_data[i], td_strb[i]));
        end
      end
      "R": begin
        send_beat({4'h0, td_addr[i][27:0]}, 2'b10);
        @(posedge axis_clk);
        while (cpl_count == cpl0) begin
          @(posedge axis_clk);
        end
        @(negedge axis_clk);
        while (!aa_as_tready) begin
          @(negedge axis_clk);
        end
        check("aa_as_tdata", cpl_data, td_exp[i]);
        check("completion count", cpl_count, cpl0 + 1);
        check("bus write count", wr_count, wr0);
        check("bus read count", rd_count, bus ? rd0 + 1 : rd0);
        if (bus) begin
          check("aa_as_tdata vs slave word", cpl_data, mem[td_addr[i][5:2]]);
        end
      end
      "J": begin
        send_beat(td_data[i], 2'b00);
        // nothing should follow a plain stream beat
        repeat (2) @(negedge axis_clk);
        check("mb_irq", mb_irq, td_exp[i]);
        check("completion count", cpl_count, cpl0);
        check("bus write count", wr_count, wr0);
        check("bus read count", rd_count, rd0);
      end
      default: abort_run("unknown operation in the test data file");
    endcase
  endtask

  initial begin
    axis_clk = 1'b0;
    axis_rst_n = 1'b0;
    as_aa_tdata = '0;
    as_aa_tuser = '0;
    as_aa_tvalid = 1'b0;
    as_aa_tready = 1'b0;
    m_awready = 1'b0;
    m_wready = 1'b0;
    m_arready = 1'b0;
    m_rvalid = 1'b0;
    m_rdata = '0;
    // fill pattern built from the word index
    for (int w = 0; w < 16; w++) begin
      mem[w] = 32'h5a00_0000 | (w * 32'h0001_0101);
    end
    read_testdata();
    cycle_limit = td_op.size() * 200 + 5;
    repeat (5) @(negedge axis_clk);
    axis_rst_n = 1'b1;
    check("aa_as_tready", aa_as_tready, 32'd1);
    check("aa_as_tvalid", aa_as_tvalid, 32'd0);
    check("m_awvalid", m_awvalid, 32'd0);
    check("m_wvalid", m_wvalid, 32'd0);
    check("m_arvalid", m_arvalid, 32'd0);
    check("m_rready", m_rready, 32'd0);
    check("mb_irq", mb_irq, 32'd0);
    for (int i = 0; i < td_op.size(); i++) begin
      run_line(i);
    end
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/axis_axil_target.sv
/*
 * stream-side configuration target, top level
 * stream requests to local registers or an AXI-Lite master
 */

`timescale 1ns/1ps

module axis_axil_target import aa_pkg::*; #(
  parameter int p_addr_w = addr_w,
  parameter int p_data_w = data_w
) (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  // stream slave, requests from the switch
  input  logic [p_data_w-1:0]   as_aa_tdata,
  input  logic [1:0]            as_aa_tuser,
  input  logic                  as_aa_tvalid,
  output logic                  aa_as_tready,
  // stream master, read completions
  output logic [p_data_w-1:0]   aa_as_tdata,
  output logic [p_data_w/8-1:0] aa_as_tstrb,
  output logic [p_data_w/8-1:0] aa_as_tkeep,
  output logic                  aa_as_tlast,
  output logic                  aa_as_tvalid,
  output logic [1:0]            aa_as_tuser,
  input  logic                  as_aa_tready,
  // AXI-Lite master
  output logic                  m_awvalid,
  output logic [p_addr_w-1:0]   m_awaddr,
  input  logic                  m_awready,
  output logic                  m_wvalid,
  output logic [p_data_w-1:0]   m_wdata,
  output logic [p_data_w/8-1:0] m_wstrb,
  input  logic                  m_wready,
  output logic                  m_arvalid,
  output logic [p_addr_w-1:0]   m_araddr,
  input  logic                  m_arready,
  output logic                  m_rready,
  input  logic                  m_rvalid,
  input  logic [p_data_w-1:0]   m_rdata,
  output logic                  mb_irq
);

  logic                bus_wr_done;
  logic                cpl_done;
  logic [p_data_w-1:0] bus_rdata;
  logic                bus_rvalid;

  aa_req_if #(.p_addr_w(p_addr_w), .p_data_w(p_data_w)) i_req ();

  // ------------------------------------------------------------------
  // request path
  // ------------------------------------------------------------------
  ss_request_decode #(.p_addr_w(p_addr_w), .p_data_w(p_data_w)) i_decode (
    .axis_clk, .axis_rst_n,
    .as_aa_tdata, .as_aa_tuser, .as_aa_tvalid, .aa_as_tready,
    .req(i_req.decode),
    .bus_wr_done, .cpl_done
  );

  lm_execute #(.p_addr_w(p_addr_w), .p_data_w(p_data_w)) i_execute (
    .axis_clk, .axis_rst_n,
    .req(i_req.execute),
    .m_awvalid, .m_awaddr, .m_awready,
    .m_wvalid, .m_wdata, .m_wstrb, .m_wready,
    .m_arvalid, .m_araddr, .m_arready,
    .m_rready, .m_rvalid, .m_rdata,
    .bus_wr_done, .bus_rdata, .bus_rvalid
  );

  aa_mailbox_regs #(.p_data_w(p_data_w)) i_regs (
    .axis_clk, .axis_rst_n,
    .req(i_req.regs),
    .mb_irq
  );

  // completion watches the held request directly
  sm_completion #(.p_data_w(p_data_w)) i_completion (
    .axis_clk, .axis_rst_n,
    .req_valid(i_req.req_valid),
    .req_write(i_req.write),
    .req_target(i_req.target),
    .local_rdata(i_req.local_rdata),
    .bus_rdata, .bus_rvalid,
    .aa_as_tdata, .aa_as_tstrb, .aa_as_tkeep, .aa_as_tlast,
    .aa_as_tvalid, .aa_as_tuser, .as_aa_tready,
    .cpl_done
  );

endmodule

// File: verilog/sm_completion.sv
/*
 * stream master read completion
 * loads one tuser 11 beat per read and holds it until accepted
 */

`timescale 1ns/1ps

module sm_completion import aa_pkg::*; #(
  parameter int p_data_w = data_w
) (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  input  logic                  req_valid,
  input  logic                  req_write,
  input  target_t               req_target,
  input  logic [p_data_w-1:0]   local_rdata,
  input  logic [p_data_w-1:0]   bus_rdata,
  input  logic                  bus_rvalid,
  output logic [p_data_w-1:0]   aa_as_tdata,
  output logic [p_data_w/8-1:0] aa_as_tstrb,
  output logic [p_data_w/8-1:0] aa_as_tkeep,
  output logic                  aa_as_tlast,
  output logic                  aa_as_tvalid,
  output logic [1:0]            aa_as_tuser,
  input  logic                  as_aa_tready,
  output logic                  cpl_done
);

  logic req_valid_q;
  logic local_rd_start;

  // local reads complete from the register file right away
  assign local_rd_start = req_valid && !req_valid_q && !req_write &&
                          (req_target != target_bus);
  assign cpl_done = aa_as_tvalid && as_aa_tready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      req_valid_q  <= 1'b0;
      aa_as_tvalid <= 1'b0;
    end else begin
      req_valid_q <= req_valid;
      if (local_rd_start || bus_rvalid) begin
        aa_as_tvalid <= 1'b1;
      end else if (cpl_done) begin
        aa_as_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (local_rd_start) begin
      aa_as_tdata <= local_rdata;
    end else if (bus_rvalid) begin
      aa_as_tdata <= bus_rdata;
    end
  end

  // fixed sideband of a completion beat
  assign aa_as_tuser = tuser_read_cpl;
  assign aa_as_tstrb = '1;
  assign aa_as_tkeep = '0;
  assign aa_as_tlast = 1'b1;

  a_cpl_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(aa_as_tdata))
    else $error("completion beat changed under back-pressure");

endmodule

// File: verilog/aa_mailbox_regs.sv
/*
 * local register window: 8-word mailbox plus interrupt enable
 * and status, with the mailbox interrupt output
 */

`timescale 1ns/1ps

module aa_mailbox_regs import aa_pkg::*; #(
  parameter int p_data_w = data_w
) (
  input  logic     axis_clk,
  input  logic     axis_rst_n,
  aa_req_if.regs   req,
  output logic     mb_irq
);

  localparam int mb_idx_w = $clog2(mbox_words);

  logic [p_data_w-1:0] mb_regs [mbox_words];
  logic [mb_idx_w-1:0] mb_idx;
  logic                mbox_wr;
  logic                reg_wr;
  logic                intr_enable;
  logic                intr_status;

  // word select from address bits 4..2
  assign mb_idx  = req.addr[2 +: mb_idx_w];
  // a local write is presented for exactly one cycle
  assign mbox_wr = req.req_valid && req.write && (req.target == target_mbox);
  assign reg_wr  = req.req_valid && req.write && (req.target == target_reg);

  // byte-strobed mailbox update
  always_ff @(posedge axis_clk) begin
    if (mbox_wr) begin
      for (int b = 0; b < p_data_w / 8; b++) begin
        if (req.wstrb[b]) begin
          mb_regs[mb_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // offset 0 enable, offset 4 status (write one to clear)
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (reg_wr && !req.addr[2] && req.wstrb[0]) begin
        intr_enable <= req.wdata[0];
      end
      // clear has priority over a mailbox set
      if (reg_wr && req.addr[2] && req.wstrb[0] && req.wdata[0]) begin
        intr_status <= 1'b0;
      end else if (mbox_wr && (|req.wstrb)) begin
        intr_status <= 1'b1;
      end
    end
  end

  always_comb begin
    if (req.target == target_reg) begin
      req.local_rdata = {{(p_data_w-1){1'b0}}, (req.addr[2] ? intr_status : intr_enable)};
    end else begin
      req.local_rdata = mb_regs[mb_idx];
    end
  end

  assign mb_irq = intr_status && intr_enable;

endmodule

// File: verilog/lm_execute.sv
/*
 * AXI-Lite master executor
 * runs one write or read on the bus for requests outside the local window
 */

`timescale 1ns/1ps

module lm_execute import aa_pkg::*; #(
  parameter int p_addr_w = addr_w,
  parameter int p_data_w = data_w
) (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  aa_req_if.execute             req,
  output logic                  m_awvalid,
  output logic [p_addr_w-1:0]   m_awaddr,
  input  logic                  m_awready,
  output logic                  m_wvalid,
  output logic [p_data_w-1:0]   m_wdata,
  output logic [p_data_w/8-1:0] m_wstrb,
  input  logic                  m_wready,
  output logic                  m_arvalid,
  output logic [p_addr_w-1:0]   m_araddr,
  input  logic                  m_arready,
  output logic                  m_rready,
  input  logic                  m_rvalid,
  input  logic [p_data_w-1:0]   m_rdata,
  output logic                  bus_wr_done,
  output logic [p_data_w-1:0]   bus_rdata,
  output logic                  bus_rvalid
);

  lm_state_t state;
  logic      req_valid_q;
  logic      bus_start;
  logic      wr_hs;
  logic      rd_hs;

  // a request is picked up once, on the rise of req_valid
  assign bus_start = req.req_valid && !req_valid_q && (req.target == target_bus);
  // aw and w complete together
  assign wr_hs = (state == lm_write) && m_awready && m_wready;
  assign rd_hs = m_rready && m_rvalid;

  // address and data come straight from the held request
  assign m_awaddr = req.addr;
  assign m_araddr = req.addr;
  assign m_wdata  = req.wdata;
  assign m_wstrb  = req.wstrb;

  assign m_awvalid = (state == lm_write);
  assign m_wvalid  = (state == lm_write);
  assign m_arvalid = (state == lm_read_addr);
  assign m_rready  = (state == lm_read_data);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state       <= lm_idle;
      req_valid_q <= 1'b0;
      bus_wr_done <= 1'b0;
      bus_rvalid  <= 1'b0;
    end else begin
      req_valid_q <= req.req_valid;
      // single cycle end pulses, one edge after the handshake
      bus_wr_done <= wr_hs;
      bus_rvalid  <= rd_hs;
      case (state)
        lm_idle: begin
          if (bus_start) begin
            state <= req.write ? lm_write : lm_read_addr;
          end
        end
        lm_write: begin
          if (wr_hs) begin
            state <= lm_idle;
          end
        end
        lm_read_addr: begin
          if (m_arready) begin
            state <= lm_read_data;
          end
        end
        lm_read_data: begin
          if (m_rvalid) begin
            state <= lm_idle;
          end
        end
        default: state <= lm_idle;
      endcase
    end
  end

  // read data held for the completion generator
  always_ff @(posedge axis_clk) begin
    if (rd_hs) begin
      bus_rdata <= m_rdata;
    end
  end

  a_ar_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
    else $error("m_arvalid or m_araddr dropped before m_arready");

endmodule

// File: verilog/ss_request_decode.sv
/*
 * stream slave request decoder
 * collects write and read request beats, classifies the address
 * and holds the request until its executor reports the end
 */

`timescale 1ns/1ps

module ss_request_decode import aa_pkg::*; #(
  parameter int p_addr_w = addr_w,
  parameter int p_data_w = data_w
) (
  input  logic                axis_clk,
  input  logic                axis_rst_n,
  input  logic [p_data_w-1:0] as_aa_tdata,
  input  logic [1:0]          as_aa_tuser,
  input  logic                as_aa_tvalid,
  output logic                aa_as_tready,
  aa_req_if.decode            req,
  input  logic                bus_wr_done,
  input  logic                cpl_done
);

  dec_state_t state;
  dec_state_t state_nxt;
  tuser_t     beat_type;
  target_t    beat_target;
  logic       beat_ok;
  logic       hdr_beat;

  assign beat_type = tuser_t'(as_aa_tuser);
  // accept beats only while no request is held
  assign aa_as_tready = (state == dec_idle) || (state == dec_wr_data);
  assign beat_ok = as_aa_tvalid && aa_as_tready;
  // plain stream and completion beats are swallowed in idle
  assign hdr_beat = beat_ok && (state == dec_idle) &&
                    ((beat_type == tuser_write) || (beat_type == tuser_read_req));

  // window decode straight from the header beat
  always_comb begin
    if (as_aa_tdata[27:8] == mbox_window) begin
      beat_target = target_mbox;
    end else if (as_aa_tdata[27:8] == reg_window) begin
      beat_target = target_reg;
    end else begin
      beat_target = target_bus;
    end
  end

  // ------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      dec_idle: begin
        if (hdr_beat) begin
          state_nxt = (beat_type == tuser_write) ? dec_wr_data : dec_issue;
        end
      end
      dec_wr_data: begin
        if (beat_ok) begin
          state_nxt = dec_issue;
        end
      end
      // local writes finish at the edge that ends this cycle
      dec_issue: begin
        state_nxt = (req.write && (req.target != target_bus)) ? dec_idle : dec_wait;
      end
      dec_wait: begin
        if ((req.write && bus_wr_done) || (!req.write && cpl_done)) begin
          state_nxt = dec_idle;
        end
      end
      default: state_nxt = dec_idle;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= dec_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // request is valid from one cycle after its last beat
  assign req.req_valid = (state == dec_issue) || (state == dec_wait);

  // header beat carries strobe in 31..28 and address in 27..0
  always_ff @(posedge axis_clk) begin
    if (hdr_beat) begin
      req.write  <= (beat_type == tuser_write);
      req.target <= beat_target;
      req.wstrb  <= as_aa_tdata[31 -: strb_w];
      req.addr   <= p_addr_w'({local_bus_prefix, as_aa_tdata[27:0]});
    end
    // second beat of a write is the data word
    if (beat_ok && (state == dec_wr_data)) begin
      req.wdata <= as_aa_tdata;
    end
  end

  // executors rely on a frozen request while it is held
  a_req_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    req.req_valid ##1 req.req_valid |->
      $stable({req.write, req.target, req.addr, req.wdata, req.wstrb}))
    else $error("request fields changed while req_valid was high");

endmodule

// File: verilog/aa_req_if.sv
/*
 * one decoded configuration request, from the stream decoder
 * to the bus executor and the local register file
 */

`timescale 1ns/1ps

interface aa_req_if import aa_pkg::*; #(
  parameter int p_addr_w = addr_w,
  parameter int p_data_w = data_w
) ();

  // request qualifier, held until the request ends
  logic                  req_valid;
  logic                  write;
  target_t               target;
  // address already carries the bus prefix in bits 31..28
  logic [p_addr_w-1:0]   addr;
  logic [p_data_w-1:0]   wdata;
  logic [p_data_w/8-1:0] wstrb;
  // read data of the local window, combinational from addr
  logic [p_data_w-1:0]   local_rdata;

  modport decode (output req_valid, write, target, addr, wdata, wstrb);

  modport execute (input req_valid, write, target, addr, wdata, wstrb);

  modport regs (
    input  req_valid, write, target, addr, wdata, wstrb,
    output local_rdata
  );

endinterface

// File: verilog/aa_pkg.sv
/*
 * stream-side configuration target, shared definitions
 * widths, stream cycle codes, register window and state encodings
 */

package aa_pkg;

  // ------------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;
  // strobe field carried in the write header beat
  localparam int strb_w = 4;

  // stream cycle type, carried on tuser
  typedef enum logic [1:0] {
    tuser_axis     = 2'b00,
    tuser_write    = 2'b01,
    tuser_read_req = 2'b10,
    tuser_read_cpl = 2'b11
  } tuser_t;

  // where a decoded request is executed
  typedef enum logic [1:0] {
    target_bus,
    target_mbox,
    target_reg
  } target_t;

  typedef enum logic [1:0] {
    dec_idle,
    dec_wr_data,
    dec_issue,
    dec_wait
  } dec_state_t;

  typedef enum logic [1:0] {
    lm_idle,
    lm_write,
    lm_read_addr,
    lm_read_data
  } lm_state_t;

  // ------------------------------------------------------------------
  // local window, compared against address bits 27..8
  // ------------------------------------------------------------------
  localparam logic [19:0] mbox_window = 20'h00020;
  localparam logic [19:0] reg_window  = 20'h00021;
  // forced into address bits 31..28 of bus transactions
  localparam logic [3:0] local_bus_prefix = 4'h3;
  localparam int mbox_words = 8;

endpackage
